// File: hdl/router_consts.svh
`ifndef ROUTER_CONSTS_SVH
`define ROUTER_CONSTS_SVH

// ##################################################
// router geometry
// ##################################################

// input ports in the order Local, North, East, West, South
`define NUM_PORTS 5

// flit field widths
`define FLIT_DATA_W 16
`define KIND_W 3
`define LEN_W 12

// input queue size, address width must cover the depth
`define FIFO_DEPTH 8
`define FIFO_AW 3

`endif

// File: hdl/routerPkg.sv
`default_nettype none

`include "router_consts.svh"

package routerPkg;

  typedef logic [`FLIT_DATA_W-1:0] flitData_t;

  // 3'b001 marks a header flit, everything else is body or tail
  typedef logic [`KIND_W-1:0] flitKind_t;

  // hold limit in clock cycles
  typedef logic [`LEN_W-1:0] pktLen_t;

  // bit 0 is Local, bit 4 is South
  typedef logic [`NUM_PORTS-1:0] portMask_t;

  // one-hot, bit 0 is idle and bits 5:1 line up with portMask_t
  typedef enum logic [5:0] {
    ARB_IDLE  = 6'b000001,
    ARB_LOCAL = 6'b000010,
    ARB_NORTH = 6'b000100,
    ARB_EAST  = 6'b001000,
    ARB_WEST  = 6'b010000,
    ARB_SOUTH = 6'b100000
  } arbState_t;

endpackage

`default_nettype wire

// File: hdl/flitFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module flitFifo
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      write,
  input  flitKind_t wrKind,
  input  pktLen_t   wrLength,
  input  flitData_t wrData,
  input  logic      pop,
  output logic      full,
  output logic      notEmpty,
  output flitKind_t headKind,
  output pktLen_t   headLength,
  output flitData_t headData
);

  flitKind_t kindMem [`FIFO_DEPTH];
  pktLen_t   lenMem  [`FIFO_DEPTH];
  flitData_t dataMem [`FIFO_DEPTH];

  logic [`FIFO_AW-1:0] wrPtr;
  logic [`FIFO_AW-1:0] rdPtr;
  logic [`FIFO_AW:0]   memCount;
  logic [`FIFO_AW:0]   occupancy;
  logic                doWrite;
  logic                doPop;
  logic                loadHead;

  // the head register counts toward capacity, so the queue holds FIFO_DEPTH flits in total
  assign occupancy = memCount + (`FIFO_AW+1)'(notEmpty);
  assign full      = (occupancy == (`FIFO_AW+1)'(`FIFO_DEPTH));

  assign doWrite  = write & ~full;
  assign doPop    = pop & notEmpty;
  // refill the head whenever it is empty or being consumed this cycle
  assign loadHead = (memCount != '0) & (~notEmpty | doPop);

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      kindMem[wrPtr] <= wrKind;
      lenMem[wrPtr]  <= wrLength;
      dataMem[wrPtr] <= wrData;
    end
  end

  always_ff @(posedge clk)
  begin
    if (loadHead)
    begin
      headKind   <= kindMem[rdPtr];
      headLength <= lenMem[rdPtr];
      headData   <= dataMem[rdPtr];
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      memCount <= '0;
      notEmpty <= 1'b0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= wrPtr + 1'b1;
      if (loadHead)
        rdPtr <= rdPtr + 1'b1;
      if (doWrite && !loadHead)
        memCount <= memCount + 1'b1;
      else if (!doWrite && loadHead)
        memCount <= memCount - 1'b1;
      if (loadHead)
        notEmpty <= 1'b1;
      else if (doPop)
        notEmpty <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/grantTimer.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module grantTimer
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  flitKind_t headKind,
  input  pktLen_t   headLength,
  input  logic      run,
  output logic      expired
);

  localparam flitKind_t KindHeader = 3'b001;

  pktLen_t limit;
  pktLen_t count;

  // the limit follows whatever header sits at the queue head, granted or not
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headKind == KindHeader)
        limit <= headLength;
      if (run)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  assign expired = (count == limit);

endmodule

`default_nettype wire

// File: hdl/portArbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module portArbiter
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t request,
  input  flitKind_t headKind0,
  input  flitKind_t headKind1,
  input  flitKind_t headKind2,
  input  flitKind_t headKind3,
  input  flitKind_t headKind4,
  input  pktLen_t   headLength0,
  input  pktLen_t   headLength1,
  input  pktLen_t   headLength2,
  input  pktLen_t   headLength3,
  input  pktLen_t   headLength4,
  output portMask_t grant
);

  arbState_t state;
  arbState_t nextState;
  portMask_t runTimer;
  portMask_t expired;
  portMask_t keep;
  flitKind_t kindArr [`NUM_PORTS];
  pktLen_t   lengthArr [`NUM_PORTS];

  // first requesting port at or after start, wrapping South back to Local
  function automatic arbState_t pickNext(input portMask_t req, input int start);
    arbState_t pick;
    int        idx;
    pick = ARB_IDLE;
    for (int k = `NUM_PORTS - 1; k >= 0; k--)
    begin
      idx = (start + k) % `NUM_PORTS;
      if (req[idx])
        pick = arbState_t'(6'b000010 << idx);
    end
    return pick;
  endfunction

  assign kindArr   = '{headKind0, headKind1, headKind2, headKind3, headKind4};
  assign lengthArr = '{headLength0, headLength1, headLength2, headLength3, headLength4};

  // ##################################################
  // per-port hold timers
  // ##################################################

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genTimer
    grantTimer u_timer (
      .clk        (clk),
      .rst        (rst),
      .headKind   (kindArr[i]),
      .headLength (lengthArr[i]),
      .run        (runTimer[i]),
      .expired    (expired[i])
    );
  end

  // ##################################################
  // grant state machine
  // ##################################################

  assign grant = state[5:1];

  // the holder keeps the output while it still requests and its timer has not run out
  assign keep = grant & request & ~expired;

  always_comb
  begin
    runTimer  = keep;
    nextState = ARB_IDLE;
    if (|keep)
      nextState = state;
    else
    begin
      // search starts just after the current holder, the holder itself comes last
      case (state)
        ARB_IDLE:  nextState = pickNext(request, 0);
        ARB_LOCAL: nextState = pickNext(request, 1);
        ARB_NORTH: nextState = pickNext(request, 2);
        ARB_EAST:  nextState = pickNext(request, 3);
        ARB_WEST:  nextState = pickNext(request, 4);
        ARB_SOUTH: nextState = pickNext(request, 0);
        default:   nextState = ARB_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ARB_IDLE;
    else
      state <= nextState;
  end

endmodule

`default_nettype wire

// File: hdl/outputSwitch.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module outputSwitch
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  portMask_t grant,
  input  portMask_t notEmpty,
  input  flitKind_t headKind0,
  input  flitKind_t headKind1,
  input  flitKind_t headKind2,
  input  flitKind_t headKind3,
  input  flitKind_t headKind4,
  input  flitData_t headData0,
  input  flitData_t headData1,
  input  flitData_t headData2,
  input  flitData_t headData3,
  input  flitData_t headData4,
  output portMask_t pop,
  output logic      outValid,
  output flitKind_t outKind,
  output flitData_t outData,
  output portMask_t outPort
);

  flitKind_t kindArr [`NUM_PORTS];
  flitData_t dataArr [`NUM_PORTS];
  flitKind_t selKind;
  flitData_t selData;

  assign kindArr = '{headKind0, headKind1, headKind2, headKind3, headKind4};
  assign dataArr = '{headData0, headData1, headData2, headData3, headData4};

  assign pop = grant & notEmpty;

  // grant is one-hot, so at most one head is selected
  always_comb
  begin
    selKind = '0;
    selData = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i])
      begin
        selKind = kindArr[i];
        selData = dataArr[i];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    if (|pop)
    begin
      outKind <= selKind;
      outData <= selData;
      outPort <= grant;
    end
  end

endmodule

`default_nettype wire

// File: hdl/routerOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module routerOutputPort
  import routerPkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      inWrite0, inWrite1, inWrite2, inWrite3, inWrite4,
  input  flitKind_t inKind0, inKind1, inKind2, inKind3, inKind4,
  input  pktLen_t   inLength0, inLength1, inLength2, inLength3, inLength4,
  input  flitData_t inData0, inData1, inData2, inData3, inData4,
  output logic      inFull0, inFull1, inFull2, inFull3, inFull4,
  output logic      outValid,
  output flitKind_t outKind,
  output flitData_t outData,
  output portMask_t outPort
);

  portMask_t writeVec;
  portMask_t fullVec;
  portMask_t notEmpty;
  portMask_t grant;
  portMask_t pop;
  flitKind_t wrKindArr [`NUM_PORTS];
  pktLen_t   wrLengthArr [`NUM_PORTS];
  flitData_t wrDataArr [`NUM_PORTS];
  flitKind_t headKind [`NUM_PORTS];
  pktLen_t   headLength [`NUM_PORTS];
  flitData_t headData [`NUM_PORTS];

  assign writeVec    = {inWrite4, inWrite3, inWrite2, inWrite1, inWrite0};
  assign wrKindArr   = '{inKind0, inKind1, inKind2, inKind3, inKind4};
  assign wrLengthArr = '{inLength0, inLength1, inLength2, inLength3, inLength4};
  assign wrDataArr   = '{inData0, inData1, inData2, inData3, inData4};
  assign {inFull4, inFull3, inFull2, inFull1, inFull0} = fullVec;

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : genQueue
    flitFifo u_fifo (
      .clk        (clk),
      .rst        (rst),
      .write      (writeVec[i]),
      .wrKind     (wrKindArr[i]),
      .wrLength   (wrLengthArr[i]),
      .wrData     (wrDataArr[i]),
      .pop        (pop[i]),
      .full       (fullVec[i]),
      .notEmpty   (notEmpty[i]),
      .headKind   (headKind[i]),
      .headLength (headLength[i]),
      .headData   (headData[i])
    );
  end

  portArbiter u_arbiter (
    .clk         (clk),
    .rst         (rst),
    .request     (notEmpty),
    .headKind0   (headKind[0]),
    .headKind1   (headKind[1]),
    .headKind2   (headKind[2]),
    .headKind3   (headKind[3]),
    .headKind4   (headKind[4]),
    .headLength0 (headLength[0]),
    .headLength1 (headLength[1]),
    .headLength2 (headLength[2]),
    .headLength3 (headLength[3]),
    .headLength4 (headLength[4]),
    .grant       (grant)
  );

  outputSwitch u_switch (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .notEmpty  (notEmpty),
    .headKind0 (headKind[0]),
    .headKind1 (headKind[1]),
    .headKind2 (headKind[2]),
    .headKind3 (headKind[3]),
    .headKind4 (headKind[4]),
    .headData0 (headData[0]),
    .headData1 (headData[1]),
    .headData2 (headData[2]),
    .headData3 (headData[3]),
    .headData4 (headData[4]),
    .pop       (pop),
    .outValid  (outValid),
    .outKind   (outKind),
    .outData   (outData),
    .outPort   (outPort)
  );

endmodule

`default_nettype wire

// File: sim/routerOutputPortTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "router_consts.svh"

module routerOutputPortTb
  import routerPkg::*;
;

  logic      clk;
  logic      rst;
  portMask_t wrVec;
  portMask_t fullVec;
  flitKind_t kindIn [`NUM_PORTS];
  pktLen_t   lenIn [`NUM_PORTS];
  flitData_t dataIn [`NUM_PORTS];
  logic      outValid;
  flitKind_t outKind;
  flitData_t outData;
  portMask_t outPort;

  // each entry is {length, kind, data}
  logic [30:0] modelQ [`NUM_PORTS][$];
  pktLen_t     lastHdrLen [`NUM_PORTS];
  pktLen_t     curLen [`NUM_PORTS];
  int          flitsLeft [`NUM_PORTS];
  int          pktsLeft [`NUM_PORTS];

  int          seed;
  int          cycleCount = 0;
  int          errorCount;
  int          errMark;
  int          checkCount;
  int          holdChecks;
  int          rotChecks;
  int          loneChecks;
  int          loneEdge;
  logic        loneMode;
  logic        writeSeen;

  logic        prevValid;
  int          prevSrc;
  int          src;
  int          expPort;
  int          runLen;
  pktLen_t     runLimit;
  logic [30:0] expEntry;
  portMask_t   ne1;
  portMask_t   ne2;

  routerOutputPort i_dut (
    .clk       (clk),
    .rst       (rst),
    .inWrite0  (wrVec[0]),
    .inWrite1  (wrVec[1]),
    .inWrite2  (wrVec[2]),
    .inWrite3  (wrVec[3]),
    .inWrite4  (wrVec[4]),
    .inKind0   (kindIn[0]),
    .inKind1   (kindIn[1]),
    .inKind2   (kindIn[2]),
    .inKind3   (kindIn[3]),
    .inKind4   (kindIn[4]),
    .inLength0 (lenIn[0]),
    .inLength1 (lenIn[1]),
    .inLength2 (lenIn[2]),
    .inLength3 (lenIn[3]),
    .inLength4 (lenIn[4]),
    .inData0   (dataIn[0]),
    .inData1   (dataIn[1]),
    .inData2   (dataIn[2]),
    .inData3   (dataIn[3]),
    .inData4   (dataIn[4]),
    .inFull0   (fullVec[0]),
    .inFull1   (fullVec[1]),
    .inFull2   (fullVec[2]),
    .inFull3   (fullVec[3]),
    .inFull4   (fullVec[4]),
    .outValid  (outValid),
    .outKind   (outKind),
    .outData   (outData),
    .outPort   (outPort)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
    cycleCount <= cycleCount + 1;

  // ##################################################
  // helpers
  // ##################################################

  task automatic reportMismatch(input string name, input logic [31:0] expV,
                                input logic [31:0] gotV);
    $display("[ERROR] %s: expected %h, got %h", name, expV, gotV);
    errorCount++;
  endtask

  task automatic failTimeout(input string what);
    $display("timeout while %s", what);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic finishTest(input string name);
    $display("test %s finished with %0d errors", name, errorCount - errMark);
    errMark = errorCount;
  endtask

  function automatic int firstSetBit(input portMask_t m);
    for (int i = 0; i < `NUM_PORTS; i++)
      if (m[i])
        return i;
    return -1;
  endfunction

  // rotating priority, the previous holder itself is searched last
  function automatic int nextRequester(input portMask_t req, input int after);
    int idx;
    for (int step = 1; step <= `NUM_PORTS; step++)
    begin
      idx = (after + step) % `NUM_PORTS;
      if (req[idx])
        return idx;
    end
    return -1;
  endfunction

  function automatic int pendingFlits();
    int total;
    total = 0;
    for (int i = 0; i < `NUM_PORTS; i++)
      total += modelQ[i].size() + flitsLeft[i] + pktsLeft[i];
    return total;
  endfunction

  task automatic driveFlit(input int p, input flitKind_t kind, input pktLen_t len,
                           input flitData_t data, input logic expectIt);
    wrVec[p]  = 1'b1;
    kindIn[p] = kind;
    lenIn[p]  = len;
    dataIn[p] = data;
    writeSeen = 1'b1;
    if (expectIt)
      modelQ[p].push_back({len, kind, data});
  endtask

  task automatic checkQuiet();
    assert (outValid === 1'b0)
      else reportMismatch("outValid", 0, outValid);
    assert (fullVec === '0)
      else reportMismatch("inFull", 0, fullVec);
  endtask

  // a packet is a header of length L followed by L body flits, the last one a tail
  task automatic trafficCycle(input int lenMin, input int lenSpan, input logic gaps);
    flitKind_t kind;
    pktLen_t   len;
    @(posedge clk);
    #0.5;
    wrVec = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      if (flitsLeft[p] == 0 && pktsLeft[p] > 0 && !(gaps && ({$random(seed)} % 3 == 0)))
      begin
        curLen[p]    = pktLen_t'(lenMin + {$random(seed)} % lenSpan);
        flitsLeft[p] = curLen[p] + 1;
        pktsLeft[p]--;
      end
      // a full queue would drop the flit, so it waits for a later cycle
      if (flitsLeft[p] > 0 && !fullVec[p])
      begin
        len = pktLen_t'($random(seed));
        if (flitsLeft[p] == curLen[p] + 1)
        begin
          kind = 3'b001;
          len  = curLen[p];
        end
        else if (flitsLeft[p] == 1)
          kind = 3'b100;
        else
          kind = 3'b010;
        driveFlit(p, kind, len, flitData_t'($random(seed)), 1'b1);
        flitsLeft[p]--;
      end
    end
  endtask

  task automatic runTraffic(input int lenMin, input int lenSpan, input logic gaps);
    int n;
    n = 0;
    while (pendingFlits() > 0)
    begin
      if (n == 3000)
        failTimeout("sending random packets");
      trafficCycle(lenMin, lenSpan, gaps);
      n++;
    end
  endtask

  task automatic waitDrain(input int limit);
    int n;
    n = 0;
    @(posedge clk);
    #0.5;
    wrVec = '0;
    while (pendingFlits() > 0)
    begin
      if (n == limit)
        failTimeout("waiting for the queues to drain");
      @(negedge clk);
      n++;
    end
    // once every accepted flit is out, nothing more may follow
    repeat (4)
    begin
      @(negedge clk);
      checkQuiet();
    end
  endtask

  // ##################################################
  // assertions and scoreboard
  // ##################################################

  assert property (@(posedge clk) disable iff (rst) outValid |-> $onehot(outPort))
    else
    begin
      $display("[ERROR] outPort %h is not one-hot while outValid is high",
               $sampled(outPort));
      errorCount++;
    end

  assert property (@(posedge clk) disable iff (rst) !writeSeen |-> !outValid && fullVec == '0)
    else
    begin
      $display("output or full flag active before any write");
      errorCount++;
    end

  always @(negedge clk)
  begin
    if (rst)
    begin
      prevValid = 1'b0;
      runLen    = 0;
      ne1       = '0;
      ne2       = '0;
    end
    else
    begin
      if (outValid)
      begin
        src = firstSetBit(outPort);
        if (src >= 0 && modelQ[src].size() == 0)
        begin
          $display("port %0d delivered a flit that was never accepted", src);
          errorCount++;
        end
        else if (src >= 0)
        begin
          expEntry = modelQ[src].pop_front();
          checkCount++;
          assert (outKind == expEntry[18:16])
            else reportMismatch("outKind", expEntry[18:16], outKind);
          assert (outData == expEntry[15:0])
            else reportMismatch("outData", expEntry[15:0], outData);
          if (expEntry[18:16] == 3'b001)
            lastHdrLen[src] = expEntry[30:19];
          if (loneMode)
          begin
            loneChecks++;
            assert (cycleCount == loneEdge + 3)
              else
              begin
                $display("lone flit appeared at cycle %0d instead of %0d",
                         cycleCount, loneEdge + 3);
                errorCount++;
              end
          end

          // ne2 holds the requests seen when this flit's grant was decided
          if (prevValid && src == prevSrc && (ne2 & ~outPort) != '0)
            runLen++;
          else
          begin
            runLen   = 1;
            runLimit = lastHdrLen[src];
          end
          if ((ne2 & ~outPort) != '0)
            holdChecks++;
          assert (runLen <= runLimit + 2)
            else
            begin
              $display("port %0d held the output for %0d cycles with limit %0d",
                       src, runLen, runLimit);
              errorCount++;
            end

          if (prevValid && src != prevSrc)
          begin
            rotChecks++;
            expPort = nextRequester(ne2, prevSrc);
            assert (src == expPort)
              else reportMismatch("outPort", 32'(1) << expPort, outPort);
          end
        end
        prevSrc = src;
      end
      prevValid = outValid;
      ne2       = ne1;
      ne1       = i_dut.notEmpty;
    end
  end

  // ##################################################
  // test sequence
  // ##################################################

  initial
  begin
    int holdMark;
    int rotMark;
    clk        = 1'b0;
    rst        = 1'b1;
    wrVec      = '0;
    seed       = 73;
    errorCount = 0;
    errMark    = 0;
    checkCount = 0;
    holdChecks = 0;
    rotChecks  = 0;
    loneChecks = 0;
    loneEdge   = 0;
    loneMode   = 1'b0;
    writeSeen  = 1'b0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      kindIn[p]     = '0;
      lenIn[p]      = '0;
      dataIn[p]     = '0;
      lastHdrLen[p] = '0;
      curLen[p]     = '0;
      flitsLeft[p]  = 0;
      pktsLeft[p]   = 0;
    end

    for (int i = 0; i < 5; i++)
    begin
      @(posedge clk);
      #0.5;
      if (i == 4)
        rst = 1'b0;
      @(negedge clk);
      checkQuiet();
    end
    repeat (8)
    begin
      @(negedge clk);
      checkQuiet();
    end
    finishTest("reset");

    // a zero length header lets the holder go right after its single flit
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      @(posedge clk);
      #0.5;
      loneEdge = cycleCount + 1;
      loneMode = 1'b1;
      driveFlit(p, 3'b001, '0, flitData_t'($random(seed)), 1'b1);
      waitDrain(50);
      loneMode = 1'b0;
    end
    if (loneChecks != `NUM_PORTS)
    begin
      $display("only %0d lone flits were seen", loneChecks);
      errorCount++;
    end
    finishTest("lone flit");

    for (int p = 0; p < `NUM_PORTS; p++)
      pktsLeft[p] = 6;
    runTraffic(1, 4, 1'b1);
    waitDrain(500);
    finishTest("order and integrity");

    holdMark = holdChecks;
    for (int p = 0; p < `NUM_PORTS; p++)
      pktsLeft[p] = 8;
    runTraffic(2, 4, 1'b0);
    waitDrain(500);
    if (holdChecks == holdMark)
    begin
      $display("no cycle had competing requests during the hold test");
      errorCount++;
    end
    finishTest("bounded hold");

    // North, West and South only, so the rotation has to skip ports
    rotMark     = rotChecks;
    pktsLeft[1] = 3;
    pktsLeft[3] = 3;
    pktsLeft[4] = 3;
    runTraffic(1, 2, 1'b0);
    waitDrain(300);
    if (rotChecks < rotMark + 3)
    begin
      $display("too few changes of source during the rotation test");
      errorCount++;
    end
    finishTest("rotation");

    // Local holds a long packet while East fills up behind it
    for (int t = 0; t < 24; t++)
    begin
      @(posedge clk);
      #0.5;
      wrVec = '0;
      driveFlit(0, (t == 0) ? 3'b001 : 3'b010, 12'd40, flitData_t'($random(seed)), 1'b1);
      if (t >= 6 && t < 16)
      begin
        assert (fullVec[2] == ((t - 6) >= 8))
          else reportMismatch("inFull2", (t - 6) >= 8, fullVec[2]);
        driveFlit(2, (t == 6) ? 3'b001 : 3'b010, 12'd7, flitData_t'($random(seed)),
                  (t - 6) < 8);
      end
    end
    waitDrain(300);
    finishTest("full queue");

    $display("tests 6, checks %0d, errors %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+hdl
hdl/routerPkg.sv
hdl/flitFifo.sv
hdl/grantTimer.sv
hdl/portArbiter.sv
hdl/outputSwitch.sv
hdl/routerOutputPort.sv
sim/routerOutputPortTb.sv
